/* list.f */
+incdir+verilog
verilog/mem_pkg.sv
verilog/lane_shift_mask.sv
verilog/mem_reader.sv
verilog/mem_writer.sv
verilog/mem_access_seq.sv
verilog/word_ram.sv
verilog/mem_subsystem_top.sv
tb/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_mem_subsystem -o tb_sim &&
./obj_dir/tb_sim || { echo "simulation run failed"; exit 1; }

/* tb/mem_tests.txt */
# name op(0 load, 1 store) size(0 byte, 1 half, 2 word) addr data exp_data exp_err, in hex
# exp_data is the zero-extended load result, 0 for stores and misaligned accesses
wr_w0    1 2 000 11223344 00000000 0
wr_w1    1 2 004 a5a5f00f 00000000 0
wr_w2    1 2 3fc deadbeef 00000000 0
rd_w0    0 2 000 00000000 11223344 0
rd_w1    0 2 004 00000000 a5a5f00f 0
rd_w2    0 2 3fc 00000000 deadbeef 0
wr_b1    1 0 001 ffffffcc 00000000 0
rd_m0    0 2 000 00000000 1122cc44 0
wr_h2    1 1 002 1234beef 00000000 0
rd_m1    0 2 000 00000000 beefcc44 0
wr_b7    1 0 007 00000077 00000000 0
rd_m2    0 2 004 00000000 77a5f00f 0
rd_b0    0 0 000 00000000 00000044 0
rd_b1    0 0 001 00000000 000000cc 0
rd_b2    0 0 002 00000000 000000ef 0
rd_b3    0 0 003 00000000 000000be 0
rd_h0    0 1 000 00000000 0000cc44 0
rd_h2    0 1 002 00000000 0000beef 0
mis_h1   0 1 001 00000000 00000000 1
mis_w6   1 2 006 12345678 00000000 1
mis_h3ff 1 1 3ff 0000ffff 00000000 1
mis_w1   0 2 001 00000000 00000000 1
chk_w1   0 2 004 00000000 77a5f00f 0
chk_w2   0 2 3fc 00000000 deadbeef 0

/* tb/tb_mem_subsystem.sv */
//--------------------------------------------------------------------
// Testbench for the data-memory subsystem
// Vectors from the tests file, shadow RAM model, response stalls,
// latency checks and a random access mix
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module tb_mem_subsystem;

    localparam int timeout_cycles = 40;

    logic              clk;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    mem_pkg::mem_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    mem_pkg::mem_rsp_t rsp;

    logic [`MEM_WORD_BITS-1:0] shadow [`MEM_DEPTH_WORDS];
    integer                    seed;

    mem_subsystem_top dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    // Loads read lanes from the shadow and aligned stores replace them
    task automatic model_access(input mem_pkg::mem_req_t r, output mem_pkg::mem_rsp_t p);
        int bytes;
        int off;
        int idx;
        bytes = ((1 << r.size) > `MEM_LANES) ? `MEM_LANES : (1 << r.size);
        off = int'(r.addr) % `MEM_LANES;
        idx = int'(r.addr) / `MEM_LANES;
        p.align_err = (off % bytes) != 0;
        p.was_store = (r.op == mem_pkg::op_store);
        p.data = '0;
        for (int b = 0; b < bytes && !p.align_err; b++)
            if (p.was_store)
                shadow[idx][8*(off+b) +: 8] = r.data[8*b +: 8];
            else
                p.data[8*b +: 8] = shadow[idx][8*(off+b) +: 8];
    endtask

    task automatic compare_rsp_data(input string name, input mem_pkg::mem_rsp_t exp,
                                    input mem_pkg::mem_rsp_t act);
        if (act.data !== exp.data)
        begin
            $display("mismatch %s: data expected %h actual %h", name, exp.data, act.data);
            abort_run();
        end
        if (act.was_store !== exp.was_store)
        begin
            $display("mismatch %s: was_store expected %b actual %b",
                     name, exp.was_store, act.was_store);
            abort_run();
        end
    endtask

    task automatic compare_align_err(input string name, input mem_pkg::mem_rsp_t exp,
                                     input mem_pkg::mem_rsp_t act);
        if (act.align_err !== exp.align_err)
        begin
            $display("mismatch %s: align_err expected %b actual %b",
                     name, exp.align_err, act.align_err);
            abort_run();
        end
    endtask

    // Counts falling edges until req_ready or rsp_valid is seen high
    task automatic wait_signal(input string name, input logic want_rsp, output int cycles);
        cycles = 0;
        while (want_rsp ? !rsp_valid : !req_ready)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout_cycles)
            begin
                $display("%s: timed out waiting for %s", name,
                         want_rsp ? "rsp_valid" : "req_ready");
                abort_run();
            end
        end
    endtask

    // Starts and ends at a falling edge
    task automatic run_access(input string name, input mem_pkg::mem_req_t r,
                              input mem_pkg::mem_rsp_t exp);
        int cycles;
        int want;
        mem_pkg::mem_rsp_t held;
        req = r;
        req_valid = 1'b1;
        wait_signal(name, 1'b0, cycles);
        @(negedge clk);
        req_valid = 1'b0;
        wait_signal(name, 1'b1, cycles);
        // Edges counted from acceptance
        want = exp.align_err ? 1 : (exp.was_store ? 4 : 3);
        if (cycles != want)
        begin
            $display("mismatch %s: latency expected %0d actual %0d", name, want, cycles);
            abort_run();
        end
        held = rsp;
        repeat ($unsigned($random(seed)) % 4)
        begin
            @(negedge clk);
            if (!rsp_valid || rsp !== held)
            begin
                $display("%s: response dropped or changed while stalled", name);
                abort_run();
            end
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
        if (rsp_valid)
        begin
            $display("%s: response still valid after it was taken", name);
            abort_run();
        end
        compare_align_err(name, exp, held);
        compare_rsp_data(name, exp, held);
    endtask

    task automatic run_file_tests();
        int fd;
        string line;
        string name;
        logic [31:0] op, size, addr, data, exp_data, exp_err;
        mem_pkg::mem_req_t r;
        mem_pkg::mem_rsp_t exp;
        mem_pkg::mem_rsp_t model;
        fd = $fopen("tb/mem_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tb/mem_tests.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if ($sscanf(line, "%s %h %h %h %h %h %h", name, op, size, addr, data,
                        exp_data, exp_err) != 7)
            begin
                $display("badly formed line in the tests file: %s", line);
                abort_run();
            end
            r.op = mem_pkg::mem_op_e'(op[0]);
            r.size = mem_pkg::access_size_e'(size[1:0]);
            r.addr = addr[`MEM_ADDR_BITS-1:0];
            r.data = data[`MEM_WORD_BITS-1:0];
            exp.data = exp_data[`MEM_WORD_BITS-1:0];
            exp.align_err = exp_err[0];
            exp.was_store = op[0];
            // File expectation must agree with the lane rule
            model_access(r, model);
            if (model !== exp)
            begin
                $display("%s: tests file disagrees with the shadow model", name);
                abort_run();
            end
            run_access(name, r, exp);
        end
        $fclose(fd);
    endtask

    // Word fill of an eight word window, then mixed accesses inside it
    task automatic run_random_tests();
        logic [31:0]       rnd;
        int                offset;
        mem_pkg::mem_req_t r;
        mem_pkg::mem_rsp_t exp;
        for (int i = 0; i < 48; i++)
        begin
            rnd = $random(seed);
            r.op = (i < 8) ? mem_pkg::op_store : mem_pkg::mem_op_e'(rnd[0]);
            r.size = (i < 8 || rnd[2:1] == 2'd3) ? mem_pkg::size_word
                                                 : mem_pkg::access_size_e'(rnd[2:1]);
            offset = (i < 8) ? `MEM_LANES * i : int'(rnd[7:3]) % (8 * `MEM_LANES);
            r.addr = `MEM_ADDR_BITS'(32'h100 + offset);
            r.data = $random(seed);
            model_access(r, exp);
            run_access($sformatf("rand_%0d", i), r, exp);
        end
    endtask

    initial
    begin
        seed = 32'h5066_8c90;
        reset = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b1;
        if (req_ready !== 1'b1 || rsp_valid !== 1'b0)
        begin
            $display("handshake outputs are wrong after reset");
            abort_run();
        end
        run_file_tests();
        run_random_tests();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verilog/lane_shift_mask.sv */
//--------------------------------------------------------------------
// Lane mask, bit shift and alignment check for one access
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module lane_shift_mask (
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  mem_pkg::access_size_e     size,
    output mem_pkg::lane_ctl_t        lane
);

    localparam int lane_log2 = $clog2(`MEM_LANES);

    logic [1:0]                size_log2;
    logic [lane_log2-1:0]      offset;
    logic [lane_log2-1:0]      low_mask;
    logic [`MEM_LANES-1:0]     lane_sel;
    logic [`MEM_LANES-1:0]     lane_hit;
    logic [`MEM_WORD_BITS-1:0] bit_mask;

    // A word access on a narrow word covers just the whole word
    assign size_log2 = (size > lane_log2) ? 2'(lane_log2) : size;
    assign offset = addr[lane_log2-1:0];

    always_comb
    begin
        for (int i = 0; i < lane_log2; i++)
            low_mask[i] = (i < size_log2);
        for (int i = 0; i < `MEM_LANES; i++)
            lane_sel[i] = (i < (1 << size_log2));
        lane_hit = lane_sel << offset;
        // One lane bit becomes eight mask bits
        for (int i = 0; i < `MEM_LANES; i++)
            bit_mask[8*i +: 8] = {8{lane_hit[i]}};
    end

    assign lane = '{mask: bit_mask,
                    shift: {1'b0, offset, 3'b000},
                    align_err: |(offset & low_mask)};

endmodule

/* verilog/mem_access_seq.sv */
//--------------------------------------------------------------------
// Access sequencer of the data-memory unit
// Request and response handshakes, RAM read and read-modify-write,
// alignment rejection
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_access_seq (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  mem_pkg::mem_req_t         req,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output mem_pkg::mem_rsp_t         rsp,
    output mem_pkg::lane_ctl_t        lane,
    output logic                      capture,
    output logic                      merge,
    output logic [`MEM_WORD_BITS-1:0] store_data,
    input  logic [`MEM_WORD_BITS-1:0] load_data,
    input  logic [`MEM_WORD_BITS-1:0] merged_word,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [`MEM_ADDR_BITS-1:0] ram_addr,
    output logic [`MEM_WORD_BITS-1:0] ram_wdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_capture,
        st_write,
        st_respond
    } state_e;

    state_e            state;
    mem_pkg::mem_req_t req_q;
    mem_pkg::mem_rsp_t rsp_q;
    mem_pkg::mem_rsp_t rsp_next;
    logic              is_store;
    logic              rsp_load;

    lane_shift_mask lsm0 (
        .addr (req_q.addr),
        .size (req_q.size),
        .lane (lane)
    );

    assign is_store = (req_q.op == mem_pkg::op_store);

    // Misaligned accesses respond straight from the read state
    // Aligned ones settle for one cycle in respond before rsp_valid
    assign rsp_load = (state == st_read && lane.align_err) ||
                      (state == st_respond && !rsp_valid);

    always_comb
    begin
        rsp_next.align_err = lane.align_err;
        rsp_next.was_store = is_store;
        rsp_next.data = '0;
        if (!is_store && !lane.align_err)
            rsp_next.data = load_data;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state <= st_idle;
            rsp_valid <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (req_valid)
                        state <= st_read;
                st_read:
                    state <= lane.align_err ? st_respond : st_capture;
                st_capture:
                    state <= is_store ? st_write : st_respond;
                st_write:
                    state <= st_respond;
                st_respond:
                    if (rsp_valid && rsp_ready)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase

            if (rsp_load)
                rsp_valid <= 1'b1;
            else if (rsp_valid && rsp_ready)
                rsp_valid <= 1'b0;
        end
    end

    // Request and response payloads
    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            req_q <= req;
        if (rsp_load)
            rsp_q <= rsp_next;
    end

    assign req_ready = (state == st_idle);
    assign rsp = rsp_q;

    // Reader or writer works in the cycle after the RAM read
    assign capture = (state == st_capture) && !is_store;
    assign merge = (state == st_capture) && is_store;
    assign store_data = req_q.data;

    assign ram_en = (state == st_read && !lane.align_err) || (state == st_write);
    assign ram_we = (state == st_write);
    assign ram_addr = req_q.addr;
    assign ram_wdata = merged_word;

    we_needs_en: assert property (
        @(posedge clk) disable iff (!reset)
        ram_we |-> ram_en
    ) else $error("RAM write enable without RAM enable");

    rsp_held: assert property (
        @(posedge clk) disable iff (!reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
    ) else $error("response changed while stalled");

endmodule

/* verilog/mem_macros.svh */
//--------------------------------------------------------------------
// Width and depth macros for the data-memory access unit
// Word width, byte lanes, byte address width and RAM depth
//--------------------------------------------------------------------

`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Data word width of 32 or 16 bits
`define MEM_WORD_BITS 32

// Byte lanes per word
`define MEM_LANES (`MEM_WORD_BITS / 8)

// Byte address width
`define MEM_ADDR_BITS 10

// Words in the RAM, covering the whole byte address space
`define MEM_DEPTH_WORDS ((1 << `MEM_ADDR_BITS) / `MEM_LANES)

`endif

/* verilog/mem_pkg.sv */
//--------------------------------------------------------------------
// Shared types of the data-memory access unit
// Access size and op enums, request, response and lane control
//--------------------------------------------------------------------

`include "mem_macros.svh"

package mem_pkg;

    // Bits of a bit shift within one word
    localparam int shift_bits = $clog2(`MEM_WORD_BITS) + 1;

    // Value is log2 of the byte count
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // Store data sits in the low lanes
    typedef struct packed {
        mem_op_e                   op;
        access_size_e              size;
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [`MEM_WORD_BITS-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [`MEM_WORD_BITS-1:0] data;
        logic                      align_err;
        logic                      was_store;
    } mem_rsp_t;

    typedef struct packed {
        logic [`MEM_WORD_BITS-1:0] mask;
        logic [shift_bits-1:0]     shift;
        logic                      align_err;
    } lane_ctl_t;

endpackage

/* verilog/mem_reader.sv */
//--------------------------------------------------------------------
// Load path of the access unit
// Captures a RAM word and moves the selected lanes down to bit 0
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_reader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      capture,
    input  mem_pkg::lane_ctl_t        lane,
    input  logic [`MEM_WORD_BITS-1:0] ram_rdata,
    output logic [`MEM_WORD_BITS-1:0] load_data
);

    logic [`MEM_WORD_BITS-1:0] picked;

    // Masking first leaves the upper bits zero after the shift
    assign picked = ram_rdata & lane.mask;

    // Result stays put until the next capture
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            load_data <= '0;
        end
        else if (capture)
        begin
            load_data <= picked >> lane.shift;
        end
    end

    // Misaligned accesses are answered without a RAM read
    capture_aligned: assert property (
        @(posedge clk) disable iff (!reset)
        capture |-> !lane.align_err
    ) else $error("reader capture on a misaligned access");

endmodule

/* verilog/mem_subsystem_top.sv */
//--------------------------------------------------------------------
// Top of the data-memory subsystem
// Sequencer, load reader, store writer and word RAM
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_subsystem_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  mem_pkg::mem_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output mem_pkg::mem_rsp_t rsp
);

    mem_pkg::lane_ctl_t        lane;
    logic                      capture;
    logic                      merge;
    logic [`MEM_WORD_BITS-1:0] store_data;
    logic [`MEM_WORD_BITS-1:0] load_data;
    logic [`MEM_WORD_BITS-1:0] merged_word;
    logic                      ram_en;
    logic                      ram_we;
    logic [`MEM_ADDR_BITS-1:0] ram_addr;
    logic [`MEM_WORD_BITS-1:0] ram_wdata;
    logic [`MEM_WORD_BITS-1:0] ram_rdata;

    mem_access_seq seq0 (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .lane        (lane),
        .capture     (capture),
        .merge       (merge),
        .store_data  (store_data),
        .load_data   (load_data),
        .merged_word (merged_word),
        .ram_en      (ram_en),
        .ram_we      (ram_we),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata)
    );

    mem_reader reader0 (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .lane      (lane),
        .ram_rdata (ram_rdata),
        .load_data (load_data)
    );

    // Old word comes straight from the RAM read of the same access
    mem_writer writer0 (
        .clk         (clk),
        .reset       (reset),
        .merge       (merge),
        .lane        (lane),
        .old_word    (ram_rdata),
        .store_data  (store_data),
        .merged_word (merged_word)
    );

    word_ram ram0 (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* verilog/mem_writer.sv */
//--------------------------------------------------------------------
// Store path of the access unit
// Merges the store lanes into the old RAM word
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_writer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      merge,
    input  mem_pkg::lane_ctl_t        lane,
    input  logic [`MEM_WORD_BITS-1:0] old_word,
    input  logic [`MEM_WORD_BITS-1:0] store_data,
    output logic [`MEM_WORD_BITS-1:0] merged_word
);

    logic [`MEM_WORD_BITS-1:0] kept;
    logic [`MEM_WORD_BITS-1:0] placed;

    // Lanes outside the access come from the old word
    assign kept = old_word & ~lane.mask;

    // Store data moves up into the addressed lanes
    assign placed = (store_data << lane.shift) & lane.mask;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            merged_word <= '0;
        end
        else if (merge)
        begin
            merged_word <= kept | placed;
        end
    end

endmodule

/* verilog/word_ram.sv */
//--------------------------------------------------------------------
// Single-port synchronous word RAM
// Byte address in, word index taken above the lane bits
//--------------------------------------------------------------------

`timescale 1ns/100ps
`include "mem_macros.svh"

module word_ram (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [`MEM_WORD_BITS-1:0] wdata,
    output logic [`MEM_WORD_BITS-1:0] rdata
);

    localparam int lane_log2 = $clog2(`MEM_LANES);
    localparam int index_bits = `MEM_ADDR_BITS - lane_log2;

    logic [`MEM_WORD_BITS-1:0] mem [`MEM_DEPTH_WORDS];
    logic [index_bits-1:0]     index;

    // Lane bits only select bytes within the word
    assign index = addr[`MEM_ADDR_BITS-1:lane_log2];

    // Read returns the word as it was before a write in the same cycle
    always_ff @(posedge clk)
    begin
        if (en)
        begin
            if (we)
                mem[index] <= wdata;
            rdata <= mem[index];
        end
    end

endmodule
